// ==== mem_subsys.f ====
+incdir+include
rtl/mem_pkg.sv
rtl/fetch_unit.sv
rtl/load_store.sv
rtl/bus_arbiter.sv
rtl/byte_lane_ram.sv
rtl/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
TOP       := tb_mem_subsys
FILELIST  := mem_subsys.f
OBJ_DIR   := obj_dir
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== include/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
  mem_op_t     op;
  logic        fetch;
  word_t       pc;
  word_t       base;
  logic [11:0] imm;
  word_t       store;
  word_t       exp_val;  // Load result, or fetched word on fetch-only rows
} vec_t;

localparam int NUM_VECS = 33;

// op, fetch, pc, base, imm, store value, expected value
vec_t vecs [NUM_VECS] = '{
  '{OP_SW,   1'b0, 32'h000, 32'h100, 12'h004, 32'hdeadbeef, 32'h00000000},
  '{OP_LW,   1'b0, 32'h000, 32'h100, 12'h004, 32'h00000000, 32'hdeadbeef},
  '{OP_SW,   1'b0, 32'h000, 32'h200, 12'hff8, 32'h12345678, 32'h00000000},  // Negative imm
  '{OP_LW,   1'b0, 32'h000, 32'h200, 12'hff8, 32'h00000000, 32'h12345678},
  '{OP_LW,   1'b0, 32'h000, 32'h1f0, 12'h008, 32'h00000000, 32'h12345678},
  '{OP_SW,   1'b0, 32'h000, 32'h040, 12'h000, 32'h11223344, 32'h00000000},
  '{OP_SB,   1'b0, 32'h000, 32'h040, 12'h000, 32'haaaaaa80, 32'h00000000},
  '{OP_LB,   1'b0, 32'h000, 32'h040, 12'h000, 32'h00000000, 32'hffffff80},
  '{OP_LBU,  1'b0, 32'h000, 32'h040, 12'h000, 32'h00000000, 32'h00000080},
  '{OP_LW,   1'b0, 32'h000, 32'h040, 12'h000, 32'h00000000, 32'h11223380},
  '{OP_SB,   1'b0, 32'h000, 32'h040, 12'h001, 32'h5555557f, 32'h00000000},
  '{OP_LB,   1'b0, 32'h000, 32'h040, 12'h001, 32'h00000000, 32'h0000007f},
  '{OP_LBU,  1'b0, 32'h000, 32'h040, 12'h001, 32'h00000000, 32'h0000007f},
  '{OP_SB,   1'b0, 32'h000, 32'h040, 12'h002, 32'h000000ff, 32'h00000000},
  '{OP_LB,   1'b0, 32'h000, 32'h040, 12'h002, 32'h00000000, 32'hffffffff},
  '{OP_LBU,  1'b0, 32'h000, 32'h040, 12'h002, 32'h00000000, 32'h000000ff},
  '{OP_SB,   1'b0, 32'h000, 32'h040, 12'h003, 32'h12345601, 32'h00000000},
  '{OP_LB,   1'b0, 32'h000, 32'h040, 12'h003, 32'h00000000, 32'h00000001},
  '{OP_LBU,  1'b0, 32'h000, 32'h040, 12'h003, 32'h00000000, 32'h00000001},
  '{OP_LW,   1'b0, 32'h000, 32'h040, 12'h000, 32'h00000000, 32'h01ff7f80},
  '{OP_SW,   1'b0, 32'h000, 32'h080, 12'h000, 32'hcafef00d, 32'h00000000},
  '{OP_SH,   1'b0, 32'h000, 32'h080, 12'h000, 32'h00008001, 32'h00000000},
  '{OP_LH,   1'b0, 32'h000, 32'h080, 12'h000, 32'h00000000, 32'hffff8001},
  '{OP_LHU,  1'b0, 32'h000, 32'h080, 12'h000, 32'h00000000, 32'h00008001},
  '{OP_SH,   1'b0, 32'h000, 32'h090, 12'hff2, 32'hffff7abc, 32'h00000000},
  '{OP_LH,   1'b0, 32'h000, 32'h090, 12'hff2, 32'h00000000, 32'h00007abc},
  '{OP_LHU,  1'b0, 32'h000, 32'h090, 12'hff2, 32'h00000000, 32'h00007abc},
  '{OP_LW,   1'b0, 32'h000, 32'h080, 12'h000, 32'h00000000, 32'h7abc8001},
  '{OP_NONE, 1'b1, 32'h104, 32'h000, 12'h000, 32'h00000000, 32'hdeadbeef},
  '{OP_NONE, 1'b1, 32'h040, 32'h000, 12'h000, 32'h00000000, 32'h01ff7f80},
  '{OP_LW,   1'b1, 32'h1f8, 32'h080, 12'h000, 32'h00000000, 32'h7abc8001},  // Both peers
  '{OP_LH,   1'b1, 32'h080, 32'h090, 12'hff0, 32'h00000000, 32'hffff8001},
  '{OP_LBU,  1'b1, 32'h104, 32'h040, 12'h003, 32'h00000000, 32'h00000001}
};

`endif

// ==== tb/tb_mem_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys
  import mem_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int NUM_RAND   = 8;
  localparam int BYTE_AW    = RAM_AW + 2;

  `include "tb_vectors.svh"

  localparam int WATCHDOG_CYCLES = (NUM_VECS + 2 * NUM_RAND + 4) * 20;

  logic    i_clk, i_rst, i_fetch, i_start;
  mem_op_t i_op;
  word_t   i_pc, i_ir, i_base, i_store;
  word_t   o_ir, o_load;
  logic    o_ir_dv, o_load_dv, o_fetch_busy, o_lsu_busy;

  logic [7:0] ref_mem [2**BYTE_AW];  // Byte copy of the RAM
  int         seed;

  mem_subsys_top DUT (
    .i_clk(i_clk), .i_rst(i_rst), .i_fetch(i_fetch), .i_pc(i_pc), .i_start(i_start),
    .i_op(i_op), .i_ir(i_ir), .i_base(i_base), .i_store(i_store),
    .o_ir(o_ir), .o_ir_dv(o_ir_dv), .o_load(o_load), .o_load_dv(o_load_dv),
    .o_fetch_busy(o_fetch_busy), .o_lsu_busy(o_lsu_busy)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  function automatic word_t model_load(input word_t addr, input mem_op_t op);
    logic [BYTE_AW-1:0] a;
    word_t              w;
    a = addr[BYTE_AW-1:0];
    w = {ref_mem[a + BYTE_AW'(3)], ref_mem[a + BYTE_AW'(2)],
         ref_mem[a + BYTE_AW'(1)], ref_mem[a]};
    case (op)
      OP_LB:   return {{24{w[7]}}, w[7:0]};
      OP_LH:   return {{16{w[15]}}, w[15:0]};
      OP_LBU:  return {24'b0, w[7:0]};
      OP_LHU:  return {16'b0, w[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic stop_on_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_ir(input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: o_ir is %h, expected %h", $time, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_load(input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: o_load is %h, expected %h", $time, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic apply_row(input int idx, input vec_t v);
    word_t addr;
    word_t exp_ir;
    word_t exp_load;
    logic  want_load;
    logic  got_ir;
    logic  got_load;
    addr      = v.base + {{20{v.imm[11]}}, v.imm};
    exp_ir    = model_load(v.pc, OP_LW);
    exp_load  = model_load(addr, v.op);
    want_load = v.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    if (v.exp_val !== (want_load ? exp_load : v.fetch ? exp_ir : v.exp_val)) begin
      $display("vector %0d does not match the reference model", idx);
      stop_on_failure();
    end
    @(posedge i_clk);
    #2;
    i_fetch = v.fetch;
    i_pc    = v.pc;
    i_start = (v.op != OP_NONE);
    i_op    = v.op;
    i_ir    = {v.imm, 20'h12303};  // Low fields not used by the LSU
    i_base  = v.base;
    i_store = v.store;
    @(posedge i_clk);
    #2;
    i_fetch  = 1'b0;
    i_start  = 1'b0;
    got_ir   = ~v.fetch;
    got_load = ~want_load;
    if (v.fetch) check_flag("o_fetch_busy", o_fetch_busy, 1'b1);
    if (v.op != OP_NONE) check_flag("o_lsu_busy", o_lsu_busy, 1'b1);
    while (!got_ir || !got_load || o_lsu_busy || o_fetch_busy) begin
      @(negedge i_clk);
      if (o_ir_dv) begin
        check_flag("o_ir_dv", o_ir_dv, ~got_ir);
        check_flag("o_fetch_busy", o_fetch_busy, 1'b0);
        check_ir(o_ir, exp_ir);
        got_ir = 1'b1;
      end
      if (o_load_dv) begin
        check_flag("o_load_dv", o_load_dv, ~got_load);
        check_flag("o_lsu_busy", o_lsu_busy, 1'b0);
        check_load(o_load, exp_load);
        got_load = 1'b1;
      end
    end
    if (v.op inside {OP_SB, OP_SH, OP_SW}) begin
      for (int i = 0; i < (v.op == OP_SB ? 1 : v.op == OP_SH ? 2 : 4); i++) begin
        ref_mem[addr[BYTE_AW-1:0] + BYTE_AW'(i)] = v.store[8*i +: 8];
      end
    end
  endtask

  initial begin
    word_t rnd;
    word_t addr;
    seed    = 48659;
    i_clk   = 1'b0;
    i_rst   = 1'b1;
    i_fetch = 1'b0;
    i_start = 1'b0;
    i_op    = OP_NONE;
    i_pc    = '0;
    i_ir    = '0;
    i_base  = '0;
    i_store = '0;
    repeat (2) @(posedge i_clk);
    #2;
    i_rst = 1'b0;
    repeat (3) begin  // Quiet before the first strobe
      @(negedge i_clk);
      check_flag("o_ir_dv", o_ir_dv, 1'b0);
      check_flag("o_load_dv", o_load_dv, 1'b0);
      check_flag("o_fetch_busy", o_fetch_busy, 1'b0);
      check_flag("o_lsu_busy", o_lsu_busy, 1'b0);
    end
    for (int r = 0; r < NUM_VECS; r++) begin
      apply_row(r, vecs[r]);
    end
    for (int k = 0; k < NUM_RAND; k++) begin  // Random word, then load and fetch together
      rnd  = $random(seed);
      addr = 32'h300 + word_t'(4 * k);
      apply_row(NUM_VECS + 2 * k, vec_t'{OP_SW, 1'b0, 32'h0, addr, 12'h000, rnd, 32'h0});
      apply_row(NUM_VECS + 2 * k + 1, vec_t'{OP_LW, 1'b1, 32'h1f8, addr, 12'h000, 32'h0, rnd});
    end
    $display("Done: no errors");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("run hung, no result after %0d cycles", WATCHDOG_CYCLES);
    stop_on_failure();
  end

endmodule

`default_nettype wire

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top
  import mem_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_fetch,
  input  word_t   i_pc,
  input  logic    i_start,
  input  mem_op_t i_op,
  input  word_t   i_ir,
  input  word_t   i_base,
  input  word_t   i_store,
  output word_t   o_ir,
  output logic    o_ir_dv,
  output word_t   o_load,
  output logic    o_load_dv,
  output logic    o_fetch_busy,
  output logic    o_lsu_busy
);

  logic     fetch_req_dv;
  bus_req_t fetch_req;
  logic     lsu_req_dv;
  bus_req_t lsu_req;
  logic     fetch_rsp_dv;
  logic     lsu_rsp_dv;
  bus_rsp_t rsp;
  logic     ram_req_dv;
  bus_req_t ram_req;
  logic     ram_rsp_dv;
  bus_rsp_t ram_rsp;

  fetch_unit u_fetch (
    .i_clk(i_clk), .i_rst(i_rst), .i_fetch(i_fetch), .i_pc(i_pc),
    .i_rsp_dv(fetch_rsp_dv), .i_rsp(rsp),
    .o_req_dv(fetch_req_dv), .o_req(fetch_req),
    .o_ir(o_ir), .o_ir_dv(o_ir_dv), .o_fetch_busy(o_fetch_busy)
  );

  load_store u_lsu (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(i_start), .i_op(i_op),
    .i_ir(i_ir), .i_base(i_base), .i_store(i_store),
    .i_rsp_dv(lsu_rsp_dv), .i_rsp(rsp),
    .o_req_dv(lsu_req_dv), .o_req(lsu_req),
    .o_load(o_load), .o_load_dv(o_load_dv), .o_lsu_busy(o_lsu_busy)
  );

  bus_arbiter u_arb (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_fetch_req_dv(fetch_req_dv), .i_fetch_req(fetch_req),
    .i_lsu_req_dv(lsu_req_dv), .i_lsu_req(lsu_req),
    .i_ram_rsp_dv(ram_rsp_dv), .i_ram_rsp(ram_rsp),
    .o_fetch_rsp_dv(fetch_rsp_dv), .o_lsu_rsp_dv(lsu_rsp_dv), .o_rsp(rsp),
    .o_ram_req_dv(ram_req_dv), .o_ram_req(ram_req)
  );

  byte_lane_ram u_ram (
    .i_clk(i_clk), .i_req_dv(ram_req_dv), .i_req(ram_req),
    .o_rsp_dv(ram_rsp_dv), .o_rsp(ram_rsp)
  );

endmodule

`default_nettype wire

// ==== rtl/byte_lane_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_lane_ram
  import mem_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_req_dv,
  input  bus_req_t i_req,
  output logic     o_rsp_dv,
  output bus_rsp_t o_rsp
);

  word_t r_mem [RAM_WORDS];

  logic [RAM_AW-1:0] w_idx;
  logic [1:0]        w_lane;
  logic [4:0]        w_shift;
  logic [3:0]        w_be;
  word_t             w_wdata_sh;
  word_t             w_rdata;

  assign w_idx      = i_req.addr[RAM_AW+1:2];
  assign w_lane     = i_req.addr[1:0];
  assign w_shift    = {w_lane, 3'b000};
  assign w_wdata_sh = i_req.wdata << w_shift;

  always_comb begin
    case (i_req.size)
      SIZE_BYTE: w_be = 4'b0001 << w_lane;
      SIZE_HALF: w_be = 4'b0011 << w_lane;
      default:   w_be = 4'b1111;
    endcase
  end

  // Addressed lane down to bit 0, masked to the access size
  always_comb begin
    w_rdata = r_mem[w_idx] >> w_shift;
    case (i_req.size)
      SIZE_BYTE: w_rdata = w_rdata & 32'h0000_00ff;
      SIZE_HALF: w_rdata = w_rdata & 32'h0000_ffff;
      default: ;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_req_dv && i_req.write) begin
      for (int i = 0; i < 4; i++) begin
        if (w_be[i]) r_mem[w_idx][8*i +: 8] <= w_wdata_sh[8*i +: 8];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    o_rsp_dv <= i_req_dv;  // Writes are answered too
    if (i_req_dv) o_rsp.rdata <= w_rdata;
  end

endmodule

`default_nettype wire

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter
  import mem_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_fetch_req_dv,
  input  bus_req_t i_fetch_req,
  input  logic     i_lsu_req_dv,
  input  bus_req_t i_lsu_req,
  input  logic     i_ram_rsp_dv,
  input  bus_rsp_t i_ram_rsp,
  output logic     o_fetch_rsp_dv,
  output logic     o_lsu_rsp_dv,
  output bus_rsp_t o_rsp,
  output logic     o_ram_req_dv,
  output bus_req_t o_ram_req
);

  logic     r_fetch_pend;
  logic     r_lsu_pend;
  bus_req_t r_fetch_slot;
  bus_req_t r_lsu_slot;
  logic     r_busy;
  logic     r_owner_lsu;  // Also the last served peer

  logic w_ram_free;
  logic w_grant;
  logic w_pick_lsu;

  // RAM answers one cycle after issue, so the response cycle is free too
  assign w_ram_free = ~r_busy | i_ram_rsp_dv;
  assign w_grant    = w_ram_free & (r_fetch_pend | r_lsu_pend);
  assign w_pick_lsu = r_lsu_pend & (~r_fetch_pend | ~r_owner_lsu);  // Round robin on a tie

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_fetch_pend <= 1'b0;
      r_lsu_pend   <= 1'b0;
      r_busy       <= 1'b0;
      r_owner_lsu  <= 1'b0;
      o_ram_req_dv <= 1'b0;
    end else begin
      o_ram_req_dv <= w_grant;
      if (i_ram_rsp_dv) r_busy <= 1'b0;
      if (w_grant) begin
        r_busy      <= 1'b1;
        r_owner_lsu <= w_pick_lsu;
        if (w_pick_lsu) r_lsu_pend <= 1'b0;
        else r_fetch_pend <= 1'b0;
      end
      if (i_fetch_req_dv) r_fetch_pend <= 1'b1;
      if (i_lsu_req_dv) r_lsu_pend <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fetch_req_dv) r_fetch_slot <= i_fetch_req;
    if (i_lsu_req_dv) r_lsu_slot <= i_lsu_req;
    if (w_grant) o_ram_req <= w_pick_lsu ? r_lsu_slot : r_fetch_slot;
  end

  // Response goes straight back to the owner
  assign o_fetch_rsp_dv = i_ram_rsp_dv & ~r_owner_lsu;
  assign o_lsu_rsp_dv   = i_ram_rsp_dv & r_owner_lsu;
  assign o_rsp          = i_ram_rsp;

endmodule

`default_nettype wire

// ==== rtl/load_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_store
  import mem_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_start,
  input  mem_op_t  i_op,
  input  word_t    i_ir,
  input  word_t    i_base,
  input  word_t    i_store,
  input  logic     i_rsp_dv,
  input  bus_rsp_t i_rsp,
  output logic     o_req_dv,
  output bus_req_t o_req,
  output word_t    o_load,
  output logic     o_load_dv,
  output logic     o_lsu_busy
);

  peer_state_t r_state;
  mem_op_t     r_op;

  word_t     w_se_offset;
  word_t     w_addr;
  word_t     w_wdata;
  acc_size_t w_size;
  logic      w_write;
  logic      w_issue;
  logic      w_done;
  logic      w_is_load;
  word_t     w_load;

  assign w_se_offset = {{($bits(word_t) - (IMM_MSB - IMM_LSB + 1)){i_ir[IMM_MSB]}},
                        i_ir[IMM_MSB:IMM_LSB]};
  assign w_addr      = i_base + w_se_offset;

  // Size and store data from the op
  always_comb begin
    w_size  = SIZE_WORD;
    w_write = 1'b0;
    w_wdata = i_store;
    case (i_op)
      OP_LB, OP_LBU: w_size = SIZE_BYTE;
      OP_LH, OP_LHU: w_size = SIZE_HALF;
      OP_SB: begin
        w_size  = SIZE_BYTE;
        w_write = 1'b1;
        w_wdata = {24'b0, i_store[7:0]};
      end
      OP_SH: begin
        w_size  = SIZE_HALF;
        w_write = 1'b1;
        w_wdata = {16'b0, i_store[15:0]};
      end
      OP_SW: w_write = 1'b1;
      default: ;
    endcase
  end

  // Extension uses the latched op
  always_comb begin
    case (r_op)
      OP_LB:   w_load = {{24{i_rsp.rdata[7]}}, i_rsp.rdata[7:0]};
      OP_LH:   w_load = {{16{i_rsp.rdata[15]}}, i_rsp.rdata[15:0]};
      OP_LBU:  w_load = {24'b0, i_rsp.rdata[7:0]};
      OP_LHU:  w_load = {16'b0, i_rsp.rdata[15:0]};
      default: w_load = i_rsp.rdata;
    endcase
  end

  assign w_is_load  = (r_op == OP_LB) || (r_op == OP_LH) || (r_op == OP_LW) ||
                      (r_op == OP_LBU) || (r_op == OP_LHU);
  assign w_issue    = (r_state == ST_READY) && i_start && (i_op != OP_NONE);
  assign w_done     = (r_state == ST_WAITING) && i_rsp_dv;
  assign o_lsu_busy = (r_state == ST_WAITING);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_state   <= ST_READY;
      r_op      <= OP_NONE;
      o_req_dv  <= 1'b0;
      o_load_dv <= 1'b0;
    end else begin
      o_req_dv  <= w_issue;
      o_load_dv <= w_done && w_is_load;  // Stores finish silently
      if (w_issue) begin
        r_state <= ST_WAITING;
        r_op    <= i_op;
      end else if (w_done) begin
        r_state <= ST_READY;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_issue) o_req <= '{addr: w_addr, wdata: w_wdata, size: w_size, write: w_write};
    if (w_done && w_is_load) o_load <= w_load;
  end

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
  import mem_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_fetch,
  input  word_t    i_pc,
  input  logic     i_rsp_dv,
  input  bus_rsp_t i_rsp,
  output logic     o_req_dv,
  output bus_req_t o_req,
  output word_t    o_ir,
  output logic     o_ir_dv,
  output logic     o_fetch_busy
);

  peer_state_t r_state;

  logic w_issue;
  logic w_done;

  assign w_issue      = (r_state == ST_READY) && i_fetch;
  assign w_done       = (r_state == ST_WAITING) && i_rsp_dv;
  assign o_fetch_busy = (r_state == ST_WAITING);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_state  <= ST_READY;
      o_req_dv <= 1'b0;
      o_ir_dv  <= 1'b0;
    end else begin
      o_req_dv <= w_issue;
      o_ir_dv  <= w_done;
      if (w_issue) r_state <= ST_WAITING;
      else if (w_done) r_state <= ST_READY;  // Strobes while waiting are dropped
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_issue) o_req <= '{addr: i_pc, wdata: '0, size: SIZE_WORD, write: 1'b0};
    if (w_done) o_ir <= i_rsp.rdata;
  end

endmodule

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  typedef logic [31:0] word_t;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } acc_size_t;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_LB,
    OP_LH,
    OP_LW,
    OP_LBU,
    OP_LHU,
    OP_SB,
    OP_SH,
    OP_SW
  } mem_op_t;

  // Shared by both peers
  typedef enum logic {
    ST_READY,
    ST_WAITING
  } peer_state_t;

  typedef struct packed {
    word_t     addr;
    word_t     wdata;  // Low bits for sub-word stores
    acc_size_t size;
    logic      write;
  } bus_req_t;

  typedef struct packed {
    word_t rdata;  // Selected lane in low bits
  } bus_rsp_t;

  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = $clog2(RAM_WORDS);
  localparam int IMM_MSB   = 31;
  localparam int IMM_LSB   = 20;

endpackage

`default_nettype wire
